// File: hw/ex_pkg.sv
// ------------------------------------------------
// Shared widths, types and one-hot opcode bit positions
// for the execute cluster; imported by every RTL module
// ------------------------------------------------
package ex_pkg;

   // Datapath width, fixed by move-high layout and 5-bit shift amount
   localparam int DATA_W = 32;

   // Architectural register file
   localparam int NUM_REGS = 32;
   localparam int REG_ADDR_W = 5;

   // One-hot ALU opcode width
   localparam int ALU_OPC_W = 9;

   // Retire counter width, wraps around
   localparam int RETIRE_W = 16;

   // Operand or result word
   typedef logic [DATA_W-1:0] data_t;

   // Register index
   typedef logic [REG_ADDR_W-1:0] reg_addr_t;

   // One-hot opcode bus
   typedef logic [ALU_OPC_W-1:0] alu_opc_t;

   // Retired instruction count
   typedef logic [RETIRE_W-1:0] retire_cnt_t;

   // Opcode bit positions
   localparam int ALU_ADD = 0;
   localparam int ALU_SUB = 1;
   localparam int ALU_AND = 2;
   localparam int ALU_OR  = 3;
   localparam int ALU_XOR = 4;
   // Shifter group
   localparam int ALU_LSL = 5;
   localparam int ALU_LSR = 6;
   localparam int ALU_ASR = 7;
   // Operand-2 bits 16..0 to bits 31..15
   localparam int ALU_MHI = 8;

endpackage

// File: hw/ex_issue.sv
// ------------------------------------------------
// Issue stage: reads operands per lane and registers
// the bundle toward the execute lanes
// ------------------------------------------------
`timescale 1ns/1ps

module ex_issue
   import ex_pkg::*;
#(
   parameter int NUM_LANES = 2
)
(
   input  logic                       clk,
   input  logic                       rst_n,
   // Incoming bundle, one slot per lane
   input  logic      [NUM_LANES-1:0]  issue_valid,
   input  alu_opc_t  [NUM_LANES-1:0]  issue_opc,
   input  reg_addr_t [NUM_LANES-1:0]  issue_rd,
   input  reg_addr_t [NUM_LANES-1:0]  issue_rs1,
   input  reg_addr_t [NUM_LANES-1:0]  issue_rs2,
   input  data_t     [NUM_LANES-1:0]  issue_imm,
   input  logic      [NUM_LANES-1:0]  issue_use_imm,
   // Register file read ports
   output reg_addr_t [NUM_LANES-1:0]  rd_addr1,
   output reg_addr_t [NUM_LANES-1:0]  rd_addr2,
   input  data_t     [NUM_LANES-1:0]  rd_data1,
   input  data_t     [NUM_LANES-1:0]  rd_data2,
   // Toward the lanes
   output logic      [NUM_LANES-1:0]  ex_valid,
   output alu_opc_t  [NUM_LANES-1:0]  ex_opc,
   output reg_addr_t [NUM_LANES-1:0]  ex_rd,
   output data_t     [NUM_LANES-1:0]  ex_operand1,
   output data_t     [NUM_LANES-1:0]  ex_operand2
);

   // Operand 2 after immediate select
   data_t [NUM_LANES-1:0] operand2_sel;

   // Source indices go straight to the read ports
   assign rd_addr1 = issue_rs1;
   assign rd_addr2 = issue_rs2;

   always_comb
   begin
      for (int l = 0; l < NUM_LANES; l++)
      begin
         // Immediate replaces the rs2 read
         operand2_sel[l] = issue_use_imm[l] ? issue_imm[l] : rd_data2[l];
      end
   end

   // Valid strobes, cleared by reset
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         ex_valid <= '0;
      else
         ex_valid <= issue_valid;
   end

   // Payload, loaded every cycle
   always_ff @(posedge clk)
   begin
      ex_opc      <= issue_opc;
      ex_rd       <= issue_rd;
      ex_operand1 <= rd_data1;
      ex_operand2 <= operand2_sel;
   end

endmodule

// File: hw/ex_alu.sv
// ------------------------------------------------
// Combinational ALU of one lane; adder result comes
// in from the lane, output picked by a one-hot AND-OR mux
// ------------------------------------------------
`timescale 1ns/1ps

module ex_alu
   import ex_pkg::*;
#(
   parameter int CONFIG_ENABLE_ASR = 1
)
(
   input  alu_opc_t  ex_alu_opc_bus,
   input  data_t     ex_operand1,
   input  data_t     ex_operand2,
   // Sum or difference from the lane adder
   input  data_t     add_sum,
   output data_t     alu_result
);

   data_t dat_and;
   data_t dat_or;
   data_t dat_xor;
   data_t dat_shifter;
   data_t dat_move;
   data_t shift_lsw;
   data_t shift_right;
   logic  sel_adder;
   logic  sel_shifter;

   // Bit reversal turns a left shift into a right shift
   function automatic data_t reverse_bits(input data_t a);
      data_t r;
      for (int i = 0; i < DATA_W; i++)
         r[DATA_W-1-i] = a[i];
      return r;
   endfunction

   // Add and subtract share one adder
   assign sel_adder = ex_alu_opc_bus[ALU_ADD] | ex_alu_opc_bus[ALU_SUB];

   // Logic unit
   assign dat_and = ex_operand1 & ex_operand2;
   assign dat_or  = ex_operand1 | ex_operand2;
   assign dat_xor = ex_operand1 ^ ex_operand2;

   // Shifter input, reversed for LSL
   assign shift_lsw = ex_alu_opc_bus[ALU_LSL] ? reverse_bits(ex_operand1) : ex_operand1;

   generate
      if (CONFIG_ENABLE_ASR != 0)
      begin : gen_asr
         data_t               shift_msw;
         logic [2*DATA_W-1:0] shift_wide;

         // Upper half holds sign copies for ASR, zeros otherwise
         assign shift_msw  = ex_alu_opc_bus[ALU_ASR] ? {DATA_W{ex_operand1[DATA_W-1]}} : '0;
         assign shift_wide = {shift_msw, shift_lsw} >> ex_operand2[4:0];
         assign shift_right = shift_wide[DATA_W-1:0];
      end
      else
      begin : gen_no_asr
         // ASR falls back to zero fill
         assign shift_right = shift_lsw >> ex_operand2[4:0];
      end
   endgenerate

   // Undo the reversal for LSL
   assign dat_shifter = ex_alu_opc_bus[ALU_LSL] ? reverse_bits(shift_right) : shift_right;
   assign sel_shifter = ex_alu_opc_bus[ALU_LSL] | ex_alu_opc_bus[ALU_LSR]
                      | ex_alu_opc_bus[ALU_ASR];

   // Move-high, low 15 bits cleared
   assign dat_move = {ex_operand2[16:0], 15'b0};

   // One-hot result mux
   assign alu_result = ({DATA_W{sel_adder}}               & add_sum)
                     | ({DATA_W{ex_alu_opc_bus[ALU_AND]}} & dat_and)
                     | ({DATA_W{ex_alu_opc_bus[ALU_OR]}}  & dat_or)
                     | ({DATA_W{ex_alu_opc_bus[ALU_XOR]}} & dat_xor)
                     | ({DATA_W{sel_shifter}}             & dat_shifter)
                     | ({DATA_W{ex_alu_opc_bus[ALU_MHI]}} & dat_move);

endmodule

// File: hw/ex_lane.sv
// ------------------------------------------------
// One execute lane: adder, ALU and result register,
// one cycle from operands to writeback
// ------------------------------------------------
`timescale 1ns/1ps

module ex_lane
   import ex_pkg::*;
#(
   parameter int CONFIG_ENABLE_ASR = 1
)
(
   input  logic       clk,
   input  logic       rst_n,
   // From issue
   input  logic       ex_valid,
   input  alu_opc_t   ex_opc,
   input  reg_addr_t  ex_rd,
   input  data_t      ex_operand1,
   input  data_t      ex_operand2,
   // To writeback
   output logic       wb_valid,
   output reg_addr_t  wb_rd,
   output data_t      wb_result
);

   data_t add_sum;
   data_t alu_result;

   // Shared adder, subtracts when SUB is set
   assign add_sum = ex_opc[ALU_SUB] ? (ex_operand1 - ex_operand2)
                                    : (ex_operand1 + ex_operand2);

   ex_alu #(
      .CONFIG_ENABLE_ASR (CONFIG_ENABLE_ASR)
   ) u_alu (
      .ex_alu_opc_bus (ex_opc),
      .ex_operand1    (ex_operand1),
      .ex_operand2    (ex_operand2),
      .add_sum        (add_sum),
      .alu_result     (alu_result)
   );

   // Valid cleared by reset
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         wb_valid <= 1'b0;
      else
         wb_valid <= ex_valid;
   end

   // Destination and result
   always_ff @(posedge clk)
   begin
      wb_rd     <= ex_rd;
      wb_result <= alu_result;
   end

endmodule

// File: hw/ex_writeback.sv
// ------------------------------------------------
// Writeback: register file with lane-ordered writes,
// read ports for issue, commit outputs, retire counter
// ------------------------------------------------
`timescale 1ns/1ps

module ex_writeback
   import ex_pkg::*;
#(
   parameter int NUM_LANES = 2
)
(
   input  logic                       clk,
   input  logic                       rst_n,
   // From the lanes
   input  logic      [NUM_LANES-1:0]  wb_valid,
   input  reg_addr_t [NUM_LANES-1:0]  wb_rd,
   input  data_t     [NUM_LANES-1:0]  wb_result,
   // Read ports for issue
   input  reg_addr_t [NUM_LANES-1:0]  rd_addr1,
   input  reg_addr_t [NUM_LANES-1:0]  rd_addr2,
   output data_t     [NUM_LANES-1:0]  rd_data1,
   output data_t     [NUM_LANES-1:0]  rd_data2,
   // Commit
   output logic      [NUM_LANES-1:0]  commit_valid,
   output reg_addr_t [NUM_LANES-1:0]  commit_rd,
   output data_t     [NUM_LANES-1:0]  commit_data,
   output retire_cnt_t                retire_count
);

   // Architectural registers
   data_t       regs [NUM_REGS];
   // Valid lanes this cycle
   retire_cnt_t wb_count;

   // Register file, all entries zero after reset
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int r = 0; r < NUM_REGS; r++)
            regs[r] <= '0;
      end
      else
      begin
         // Lane order, so the last write to a register wins
         for (int l = 0; l < NUM_LANES; l++)
         begin
            // r0 never written
            if (wb_valid[l] && (wb_rd[l] != '0))
               regs[wb_rd[l]] <= wb_result[l];
         end
      end
   end

   // Combinational reads, r0 hardwired
   always_comb
   begin
      for (int l = 0; l < NUM_LANES; l++)
      begin
         rd_data1[l] = (rd_addr1[l] == '0) ? '0 : regs[rd_addr1[l]];
         rd_data2[l] = (rd_addr2[l] == '0) ? '0 : regs[rd_addr2[l]];
      end
   end

   // Popcount of wb_valid
   always_comb
   begin
      wb_count = '0;
      for (int l = 0; l < NUM_LANES; l++)
         wb_count = wb_count + retire_cnt_t'(wb_valid[l]);
   end

   // Control state
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         commit_valid <= '0;
         retire_count <= '0;
      end
      else
      begin
         commit_valid <= wb_valid;
         // Wraps at 2^16
         retire_count <= retire_count + wb_count;
      end
   end

   // Commit payload
   always_ff @(posedge clk)
   begin
      commit_rd   <= wb_rd;
      commit_data <= wb_result;
   end

endmodule

// File: hw/ex_cluster.sv
// ------------------------------------------------
// Execute cluster top: issue, NUM_LANES lanes and
// writeback; fixed 3-cycle issue to commit
// ------------------------------------------------
`timescale 1ns/1ps

module ex_cluster
   import ex_pkg::*;
#(
   parameter int NUM_LANES         = 2,
   parameter int CONFIG_ENABLE_ASR = 1
)
(
   input  logic                       clk,
   input  logic                       rst_n,
   // Bundle in
   input  logic      [NUM_LANES-1:0]  issue_valid,
   input  alu_opc_t  [NUM_LANES-1:0]  issue_opc,
   input  reg_addr_t [NUM_LANES-1:0]  issue_rd,
   input  reg_addr_t [NUM_LANES-1:0]  issue_rs1,
   input  reg_addr_t [NUM_LANES-1:0]  issue_rs2,
   input  data_t     [NUM_LANES-1:0]  issue_imm,
   input  logic      [NUM_LANES-1:0]  issue_use_imm,
   // Commit out
   output logic      [NUM_LANES-1:0]  commit_valid,
   output reg_addr_t [NUM_LANES-1:0]  commit_rd,
   output data_t     [NUM_LANES-1:0]  commit_data,
   output retire_cnt_t                retire_count
);

   // Read ports
   reg_addr_t [NUM_LANES-1:0] rd_addr1;
   reg_addr_t [NUM_LANES-1:0] rd_addr2;
   data_t     [NUM_LANES-1:0] rd_data1;
   data_t     [NUM_LANES-1:0] rd_data2;
   // Issue to lanes
   logic      [NUM_LANES-1:0] ex_valid;
   alu_opc_t  [NUM_LANES-1:0] ex_opc;
   reg_addr_t [NUM_LANES-1:0] ex_rd;
   data_t     [NUM_LANES-1:0] ex_operand1;
   data_t     [NUM_LANES-1:0] ex_operand2;
   // Lanes to writeback
   logic      [NUM_LANES-1:0] wb_valid;
   reg_addr_t [NUM_LANES-1:0] wb_rd;
   data_t     [NUM_LANES-1:0] wb_result;

   ex_issue #(
      .NUM_LANES (NUM_LANES)
   ) u_issue (
      .clk           (clk),
      .rst_n         (rst_n),
      .issue_valid   (issue_valid),
      .issue_opc     (issue_opc),
      .issue_rd      (issue_rd),
      .issue_rs1     (issue_rs1),
      .issue_rs2     (issue_rs2),
      .issue_imm     (issue_imm),
      .issue_use_imm (issue_use_imm),
      .rd_addr1      (rd_addr1),
      .rd_addr2      (rd_addr2),
      .rd_data1      (rd_data1),
      .rd_data2      (rd_data2),
      .ex_valid      (ex_valid),
      .ex_opc        (ex_opc),
      .ex_rd         (ex_rd),
      .ex_operand1   (ex_operand1),
      .ex_operand2   (ex_operand2)
   );

   // Identical lanes
   for (genvar l = 0; l < NUM_LANES; l++)
   begin : gen_lane
      ex_lane #(
         .CONFIG_ENABLE_ASR (CONFIG_ENABLE_ASR)
      ) u_lane (
         .clk         (clk),
         .rst_n       (rst_n),
         .ex_valid    (ex_valid[l]),
         .ex_opc      (ex_opc[l]),
         .ex_rd       (ex_rd[l]),
         .ex_operand1 (ex_operand1[l]),
         .ex_operand2 (ex_operand2[l]),
         .wb_valid    (wb_valid[l]),
         .wb_rd       (wb_rd[l]),
         .wb_result   (wb_result[l])
      );
   end

   ex_writeback #(
      .NUM_LANES (NUM_LANES)
   ) u_writeback (
      .clk          (clk),
      .rst_n        (rst_n),
      .wb_valid     (wb_valid),
      .wb_rd        (wb_rd),
      .wb_result    (wb_result),
      .rd_addr1     (rd_addr1),
      .rd_addr2     (rd_addr2),
      .rd_data1     (rd_data1),
      .rd_data2     (rd_data2),
      .commit_valid (commit_valid),
      .commit_rd    (commit_rd),
      .commit_data  (commit_data),
      .retire_count (retire_count)
   );

endmodule

// File: tb/ex_cluster_checker.sv
// ------------------------------------------------
// Protocol assertions for the execute cluster,
// bound into ex_cluster from the testbench
// ------------------------------------------------
`timescale 1ns/1ps

module ex_cluster_checker
   import ex_pkg::*;
#(
   parameter int NUM_LANES = 2
)
(
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic     [NUM_LANES-1:0]  issue_valid,
   input  alu_opc_t [NUM_LANES-1:0]  issue_opc,
   input  logic     [NUM_LANES-1:0]  commit_valid
);

   // Number of failed assertions
   int fail_count = 0;

   // Commit register loads two edges after issue is sampled
   // and the assertion sees it one edge later
   a_commit_follows_issue: assert property (
      @(posedge clk) disable iff (!rst_n)
      commit_valid == $past(issue_valid, 3)
   )
   else
   begin
      fail_count++;
      $error("commit_valid does not follow issue_valid");
   end

   // No commits while reset is held
   a_commit_low_in_reset: assert property (
      @(posedge clk) !rst_n |-> (commit_valid == '0)
   )
   else
   begin
      fail_count++;
      $error("commit_valid high during reset");
   end

   // Valid lanes carry exactly one opcode bit
   for (genvar l = 0; l < NUM_LANES; l++)
   begin : gen_onehot
      a_opc_onehot: assert property (
         @(posedge clk) disable iff (!rst_n)
         issue_valid[l] |-> $onehot(issue_opc[l])
      )
      else
      begin
         fail_count++;
         $error("lane %0d issued with a non one-hot opcode", l);
      end
   end

endmodule

// File: tb/tb_ex_cluster.sv
// ------------------------------------------------
// Random-stimulus testbench for ex_cluster; a register
// file model predicts every commit three cycles ahead
// ------------------------------------------------
`timescale 1ns/1ps

module tb_ex_cluster
   import ex_pkg::*;
;
   localparam int NUM_LANES = 2;

   // Expected commit of one bundle
   typedef struct packed {
      logic      [NUM_LANES-1:0] valid;
      reg_addr_t [NUM_LANES-1:0] rd;
      data_t     [NUM_LANES-1:0] data;
   } bundle_t;

   logic                      clk;
   logic                      rst_n;
   logic      [NUM_LANES-1:0] issue_valid;
   alu_opc_t  [NUM_LANES-1:0] issue_opc;
   reg_addr_t [NUM_LANES-1:0] issue_rd;
   reg_addr_t [NUM_LANES-1:0] issue_rs1;
   reg_addr_t [NUM_LANES-1:0] issue_rs2;
   data_t     [NUM_LANES-1:0] issue_imm;
   logic      [NUM_LANES-1:0] issue_use_imm;
   logic      [NUM_LANES-1:0] commit_valid;
   reg_addr_t [NUM_LANES-1:0] commit_rd;
   data_t     [NUM_LANES-1:0] commit_data;
   retire_cnt_t               retire_count;

   // Model state
   data_t       model_regs [NUM_REGS];
   retire_cnt_t retire_total;
   bundle_t     exp_q [$];
   logic [31:0] rng_state;
   int          errors;
   int          checks;
   logic        timed_out;

   ex_cluster #(
      .NUM_LANES         (NUM_LANES),
      .CONFIG_ENABLE_ASR (1)
   ) uut (
      .clk           (clk),
      .rst_n         (rst_n),
      .issue_valid   (issue_valid),
      .issue_opc     (issue_opc),
      .issue_rd      (issue_rd),
      .issue_rs1     (issue_rs1),
      .issue_rs2     (issue_rs2),
      .issue_imm     (issue_imm),
      .issue_use_imm (issue_use_imm),
      .commit_valid  (commit_valid),
      .commit_rd     (commit_rd),
      .commit_data   (commit_data),
      .retire_count  (retire_count)
   );

   bind ex_cluster ex_cluster_checker #(
      .NUM_LANES (NUM_LANES)
   ) u_checker (
      .clk          (clk),
      .rst_n        (rst_n),
      .issue_valid  (issue_valid),
      .issue_opc    (issue_opc),
      .commit_valid (commit_valid)
   );

   // 40 ns clock
   always #20 clk = ~clk;

   // 32-bit xorshift
   function automatic logic [31:0] next_rand();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   // ALU result straight from the opcode definitions
   function automatic data_t alu_model(input alu_opc_t opc, input data_t a, input data_t b);
      data_t r;
      r = '0;
      if (opc[ALU_ADD]) r = a + b;
      else if (opc[ALU_SUB]) r = a - b;
      else if (opc[ALU_AND]) r = a & b;
      else if (opc[ALU_OR])  r = a | b;
      else if (opc[ALU_XOR]) r = a ^ b;
      else if (opc[ALU_LSL]) r = a << b[4:0];
      else if (opc[ALU_LSR]) r = a >> b[4:0];
      else if (opc[ALU_ASR]) r = data_t'($signed(a) >>> b[4:0]);
      else if (opc[ALU_MHI]) r = b << 15;
      return r;
   endfunction

   // r0 reads zero
   function automatic data_t model_read(input reg_addr_t a);
      return (a == '0) ? '0 : model_regs[a];
   endfunction

   task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                        input string what);
      checks++;
      if (actual !== expected)
      begin
         errors++;
         $display("** Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
      end
   endtask

   task automatic set_lane(input int l, input logic v, input alu_opc_t opc,
                           input reg_addr_t rd, input reg_addr_t rs1, input reg_addr_t rs2,
                           input data_t imm, input logic use_imm);
      issue_valid[l]   = v;
      issue_opc[l]     = opc;
      issue_rd[l]      = rd;
      issue_rs1[l]     = rs1;
      issue_rs2[l]     = rs2;
      issue_imm[l]     = imm;
      issue_use_imm[l] = use_imm;
   endtask

   task automatic clear_inputs();
      for (int l = 0; l < NUM_LANES; l++)
         set_lane(l, 1'b0, '0, '0, '0, '0, '0, 1'b0);
   endtask

   // Predict the driven bundle, clock once, check the oldest one
   task automatic step();
      bundle_t b;
      bundle_t c;
      data_t   op1;
      data_t   op2;
      for (int l = 0; l < NUM_LANES; l++)
      begin
         op1 = model_read(issue_rs1[l]);
         op2 = issue_use_imm[l] ? issue_imm[l] : model_read(issue_rs2[l]);
         b.valid[l] = issue_valid[l];
         b.rd[l]    = issue_rd[l];
         b.data[l]  = alu_model(issue_opc[l], op1, op2);
      end
      exp_q.push_back(b);
      @(posedge clk);
      #2;
      c = exp_q.pop_front();
      // Lane order lets lane 1 override lane 0
      for (int l = 0; l < NUM_LANES; l++)
      begin
         check(commit_valid[l], c.valid[l], $sformatf("lane %0d commit_valid", l));
         if (c.valid[l])
         begin
            check(commit_rd[l], c.rd[l], $sformatf("lane %0d commit_rd", l));
            check(commit_data[l], c.data[l], $sformatf("lane %0d commit_data", l));
            if (c.rd[l] != '0)
               model_regs[c.rd[l]] = c.data[l];
            retire_total = retire_total + 1'b1;
         end
      end
      check(retire_count, retire_total, "retire_count");
   endtask

   task automatic finish_run();
      int assert_fails;
      assert_fails = uut.u_checker.fail_count;
      $display("Checks: %0d  errors: %0d  assertion failures: %0d",
               checks, errors, assert_fails);
      if (errors == 0 && assert_fails == 0 && !timed_out)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   endtask

   initial
   begin
      logic [31:0] rnd;
      int          cycles;
      clk          = 1'b0;
      rst_n        = 1'b1;
      rng_state    = 32'd65352;
      retire_total = '0;
      errors       = 0;
      checks       = 0;
      timed_out    = 1'b0;
      clear_inputs();
      for (int r = 0; r < NUM_REGS; r++)
         model_regs[r] = '0;
      // Reset falls after time zero so every register sees the edge
      #1;
      rst_n = 1'b0;
      for (int i = 0; i < 10; i++)
         @(posedge clk);
      #2;
      rst_n = 1'b1;
      check(commit_valid, '0, "commit_valid after reset");
      check(retire_count, '0, "retire_count after reset");

      // Single add into r0 that must commit three edges later
      set_lane(0, 1'b1, alu_opc_t'(1) << ALU_ADD, '0, '0, '0, 32'h0000_1234, 1'b1);
      cycles = 0;
      do
      begin
         @(posedge clk);
         #2;
         cycles++;
         clear_inputs();
      end
      while (commit_valid[0] !== 1'b1 && cycles < 20);

      if (commit_valid[0] !== 1'b1)
      begin
         $display("Timeout: no commit seen within 20 cycles of a single issue");
         timed_out = 1'b1;
      end
      else
      begin
         check(cycles, 3, "issue to commit latency");
         check(commit_data[0], 32'h0000_1234, "probe commit_data");
         retire_total = 1;
         // Two idle bundles already in flight
         exp_q.push_back('0);
         exp_q.push_back('0);

         // Every register reads zero through an add with r0
         for (int r = 0; r < NUM_REGS / 2; r++)
         begin
            set_lane(0, 1'b1, alu_opc_t'(1) << ALU_ADD, '0, r, '0, '0, 1'b0);
            set_lane(1, 1'b1, alu_opc_t'(1) << ALU_ADD, '0, r + 16, '0, '0, 1'b0);
            step();
         end

         // Both lanes write r5 and dependent reads follow early and late
         set_lane(0, 1'b1, alu_opc_t'(1) << ALU_ADD, 5'd5, '0, '0, 32'h11, 1'b1);
         set_lane(1, 1'b1, alu_opc_t'(1) << ALU_ADD, 5'd5, '0, '0, 32'h22, 1'b1);
         step();
         for (int i = 0; i < 4; i++)
         begin
            set_lane(0, 1'b1, alu_opc_t'(1) << ALU_OR, '0, 5'd5, '0, '0, 1'b0);
            set_lane(1, 1'b1, alu_opc_t'(1) << ALU_ADD, 5'd6, 5'd5, '0, '0, 1'b0);
            step();
         end

         // Random bundles over r0..r15 for frequent hazards
         for (int i = 0; i < 400; i++)
         begin
            for (int l = 0; l < NUM_LANES; l++)
            begin
               rnd = next_rand();
               set_lane(l, rnd[0], alu_opc_t'(1) << (rnd[8:1] % ALU_OPC_W),
                        rnd[12:9], rnd[16:13], rnd[20:17], next_rand(), rnd[21]);
            end
            step();
         end

         // Drain
         clear_inputs();
         for (int i = 0; i < 3; i++)
            step();
      end
      finish_run();
   end

endmodule

// File: verilog.f
hw/ex_pkg.sv
hw/ex_issue.sv
hw/ex_alu.sv
hw/ex_lane.sv
hw/ex_writeback.sv
hw/ex_cluster.sv
tb/ex_cluster_checker.sv
tb/tb_ex_cluster.sv

// File: Bender.yml
package:
  name: ex_cluster

sources:
  - hw/ex_pkg.sv
  - hw/ex_issue.sv
  - hw/ex_alu.sv
  - hw/ex_lane.sv
  - hw/ex_writeback.sv
  - hw/ex_cluster.sv
  - target: simulation
    files:
      - tb/ex_cluster_checker.sv
      - tb/tb_ex_cluster.sv
